/* verilog/game_pkg.sv */
`default_nettype none

package game_pkg;

  typedef enum logic [1:0] {
    st_init,
    st_set,
    st_game,
    st_final
  } game_state_e;

  // main row digits 0..9, then keypad digits 0..9
  localparam logic [8:0] key_code_table [20] = '{
    9'h045, 9'h016, 9'h01e, 9'h026, 9'h025,
    9'h02e, 9'h036, 9'h03d, 9'h03e, 9'h046,
    9'h070, 9'h069, 9'h072, 9'h07a, 9'h06b,
    9'h073, 9'h074, 9'h06c, 9'h075, 9'h07d
  };
  localparam logic [8:0] space_code = 9'h029;

  localparam logic [8:0] lfsr_seed = 9'b1_0110_0000;
  localparam logic [8:0] lfsr_taps = 9'b0_0110_1000; // bits 6, 5, 3

  localparam logic [3:0] target_ticks = 4'd8;
  localparam logic [2:0] final_ticks = 3'd4;

  localparam logic [7:0] default_time = 8'h30; // bcd
  localparam logic [7:0] default_goal = 8'h10;

  localparam logic [15:0] led_idle = 16'b1000_0000_0000_0000;
  localparam logic [15:0] led_edit_time = 16'b1111_1111_0000_0000;
  localparam logic [15:0] led_edit_goal = 16'b0000_0000_1111_1111;
  localparam logic [6:0] led_tail = 7'b000_0011;

  // glyph codes above the numerals
  localparam logic [3:0] glyph_w = 4'd10;
  localparam logic [3:0] glyph_i = 4'd11;
  localparam logic [3:0] glyph_n = 4'd12;
  localparam logic [3:0] glyph_l = 4'd13;
  localparam logic [3:0] glyph_e = 4'd14;
  localparam logic [3:0] glyph_blank = 4'd15;

  // [3] time tens, [2] time ones, [1] score tens, [0] score ones
  typedef union packed {
    logic [3:0][3:0] bcd;
    logic [3:0][3:0] glyph;
  } disp_word_u;

  localparam int tick_div_default = 50_000_000;

endpackage

`default_nettype wire

/* verilog/tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tick_gen #(
  parameter int tick_div = game_pkg::tick_div_default
) (
  input wire clk,
  input wire out_rst,
  output logic game_tick,
  output logic scan_en
);

  localparam int tick_w = $clog2(tick_div + 1);
  localparam int scan_div = (tick_div / 64 > 0) ? tick_div / 64 : 1;
  localparam int scan_w = $clog2(scan_div + 1);

  logic [tick_w-1:0] tick_cnt;
  logic [scan_w-1:0] scan_cnt;

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      tick_cnt <= '0;
      scan_cnt <= '0;
      game_tick <= 1'b0;
      scan_en <= 1'b0;
    end else begin
      game_tick <= (tick_cnt == tick_w'(tick_div - 1));
      scan_en <= (scan_cnt == scan_w'(scan_div - 1));
      tick_cnt <= (tick_cnt == tick_w'(tick_div - 1)) ? '0 : tick_cnt + 1'b1;
      scan_cnt <= (scan_cnt == scan_w'(scan_div - 1)) ? '0 : scan_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/key_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module key_receiver (
  input wire clk,
  input wire out_rst,
  input wire key_req,
  input wire [8:0] key_code,
  output logic key_ack,
  output logic key_event,
  output logic [3:0] key_digit,
  output logic key_is_digit,
  output logic key_is_space
);

  import game_pkg::*;

  logic req_s1;
  logic req_s2;
  logic req_rise;
  logic [3:0] code_digit;
  logic code_is_digit;

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      req_s1 <= 1'b0;
      req_s2 <= 1'b0;
    end else begin
      req_s1 <= key_req;
      req_s2 <= req_s1;
    end
  end

  assign req_rise = req_s1 && !req_s2;

  // table lookup, keypad entries fold onto 0..9
  always_comb begin
    code_digit = 4'd0;
    code_is_digit = 1'b0;
    for (int i = 0; i < 20; i++) begin
      if (key_code == key_code_table[i]) begin
        code_digit = 4'(i % 10);
        code_is_digit = 1'b1;
      end
    end
  end

  // key_ack doubles as the handshake state: low = idle, high = wait for req low
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      key_ack <= 1'b0;
      key_event <= 1'b0;
      key_is_digit <= 1'b0;
      key_is_space <= 1'b0;
    end else begin
      key_event <= 1'b0;
      if (!key_ack) begin
        if (req_rise) begin
          key_ack <= 1'b1;
          key_event <= 1'b1;
          key_is_digit <= code_is_digit;
          key_is_space <= (key_code == space_code);
        end
      end else if (!req_s1) begin
        key_ack <= 1'b0; // sender has let go
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!key_ack && req_rise) key_digit <= code_digit;
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (out_rst)
    $rose(key_ack) |-> $past(key_req));

endmodule

`default_nettype wire

/* verilog/target_lfsr.sv */
`timescale 1ns/10ps
`default_nettype none

module target_lfsr (
  input wire clk,
  input wire out_rst,
  input wire game_tick,
  input wire game_pkg::game_state_e state,
  output logic [8:0] lfsr_q
);

  import game_pkg::*;

  logic [8:0] lfsr_next;
  logic fb;

  assign fb = lfsr_q[0];
  // shift toward bit 0, bit 0 wraps to bit 8 and feeds the taps
  assign lfsr_next = {fb, lfsr_q[8:1]} ^ (lfsr_taps & {9{fb}});

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      lfsr_q <= lfsr_seed;
    end else if (state != st_game) begin
      lfsr_q <= lfsr_seed; // reseed while not playing
    end else if (game_tick) begin
      lfsr_q <= lfsr_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/game_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module game_ctrl (
  input wire clk,
  input wire out_rst,
  input wire start,
  input wire game_tick,
  input wire key_event,
  input wire [3:0] key_digit,
  input wire key_is_digit,
  input wire key_is_space,
  input wire [8:0] lfsr_q,
  output game_pkg::game_state_e state,
  output logic [15:0] led,
  output game_pkg::disp_word_u disp_word
);

  import game_pkg::*;

  game_state_e next_state;
  logic edit_goal; // 0 time, 1 goal
  logic [7:0] time_bcd;
  logic [7:0] goal_bcd;
  logic [6:0] time_left;
  logic [6:0] goal;
  logic [6:0] score;
  logic [3:0] tgt_cnt;
  logic refresh;
  logic [2:0] fin_cnt;
  logic win;
  logic [3:0] led_idx;
  logic hit;

  assign led_idx = 4'd15 - key_digit;
  assign hit = key_event && key_is_digit && led[led_idx];

  always_comb begin
    next_state = state;
    case (state)
      st_init:  if (start) next_state = st_set;
      st_set:   if (start) next_state = st_game;
      st_game:  if (score >= goal || time_left == 7'd0) next_state = st_final;
      st_final: if (fin_cnt == final_ticks) next_state = st_init;
      default:  next_state = st_init;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      state <= st_init;
      led <= led_idle;
      edit_goal <= 1'b0;
      time_bcd <= default_time;
      goal_bcd <= default_goal;
      time_left <= 7'd0;
      goal <= 7'd0;
      score <= 7'd0;
      tgt_cnt <= 4'd0;
      refresh <= 1'b0;
      fin_cnt <= 3'd0;
      win <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        st_init: begin
          edit_goal <= 1'b0;
          time_bcd <= default_time;
          goal_bcd <= default_goal;
          led <= start ? led_edit_time : led_idle;
        end
        st_set: begin
          if (key_event && key_is_space) begin
            edit_goal <= !edit_goal;
            led <= edit_goal ? led_edit_time : led_edit_goal;
          end else if (key_event && key_is_digit) begin
            if (edit_goal) goal_bcd <= {goal_bcd[3:0], key_digit};
            else time_bcd <= {time_bcd[3:0], key_digit};
          end
          if (start) begin
            // lfsr_q still holds the seed here
            led <= {lfsr_q, led_tail};
            time_left <= 7'(time_bcd[7:4]) * 7'd10 + 7'(time_bcd[3:0]);
            goal <= 7'(goal_bcd[7:4]) * 7'd10 + 7'(goal_bcd[3:0]);
            score <= 7'd0;
            tgt_cnt <= 4'd0;
            refresh <= 1'b0;
          end
        end
        st_game: begin
          // reload lands one clock after the tick, once the lfsr has stepped
          refresh <= game_tick && (tgt_cnt == target_ticks - 4'd1);
          if (game_tick) begin
            tgt_cnt <= (tgt_cnt == target_ticks - 4'd1) ? 4'd0 : tgt_cnt + 4'd1;
            if (time_left != 7'd0) time_left <= time_left - 7'd1;
          end
          if (refresh) begin
            led <= {lfsr_q, led_tail};
          end else if (hit) begin
            led[led_idx] <= 1'b0;
            score <= score + 7'd1;
          end
          if (next_state == st_final) begin
            win <= (score >= goal);
            fin_cnt <= 3'd0;
          end
        end
        st_final: begin
          if (next_state == st_init) led <= led_idle;
          else if (game_tick) begin
            led <= ~led; // flash
            fin_cnt <= fin_cnt + 3'd1;
          end
        end
        default: led <= led_idle;
      endcase
    end
  end

  always_comb begin
    disp_word.glyph = {4{glyph_blank}};
    case (state)
      st_set:  disp_word.bcd = {time_bcd, goal_bcd};
      st_game: begin
        disp_word.bcd[3] = 4'(time_left / 7'd10);
        disp_word.bcd[2] = 4'(time_left % 7'd10);
        disp_word.bcd[1] = 4'(score / 7'd10);
        disp_word.bcd[0] = 4'(score % 7'd10);
      end
      st_final: begin
        if (win) disp_word.glyph = {glyph_w, glyph_i, glyph_n, glyph_blank};
        else disp_word.glyph = {glyph_l, 4'd0, 4'd5, glyph_e}; // O and S from 0, 5
      end
      default: disp_word.glyph = {4{glyph_blank}};
    endcase
  end

  // digit keys only act on targets during play
  a_no_led_from_key: assert property (@(posedge clk) disable iff (out_rst)
    key_event && key_is_digit && state != st_game && next_state == state && !game_tick
    |=> $stable(led));

  a_state_known: assert property (@(posedge clk) disable iff (out_rst)
    !$isunknown(state));

endmodule

`default_nettype wire

/* verilog/seg_display.sv */
`timescale 1ns/10ps
`default_nettype none

module seg_display (
  input wire clk,
  input wire out_rst,
  input wire scan_en,
  input wire game_pkg::disp_word_u disp_word,
  output logic [3:0] digit,
  output logic [6:0] seg
);

  import game_pkg::*;

  logic [3:0] nib;

  // active low select, rightmost digit first
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      digit <= 4'b1111;
    end else if (scan_en) begin
      digit <= (digit == 4'b1111) ? 4'b1110 : {digit[2:0], digit[3]};
    end
  end

  always_comb begin
    case (digit)
      4'b1110: nib = disp_word.glyph[0];
      4'b1101: nib = disp_word.glyph[1];
      4'b1011: nib = disp_word.glyph[2];
      4'b0111: nib = disp_word.glyph[3];
      default: nib = glyph_blank;
    endcase
  end

  // gfedcba, low = lit
  always_comb begin
    case (nib)
      4'd0:    seg = 7'b100_0000;
      4'd1:    seg = 7'b111_1001;
      4'd2:    seg = 7'b010_0100;
      4'd3:    seg = 7'b011_0000;
      4'd4:    seg = 7'b001_1001;
      4'd5:    seg = 7'b001_0010;
      4'd6:    seg = 7'b000_0010;
      4'd7:    seg = 7'b111_1000;
      4'd8:    seg = 7'b000_0000;
      4'd9:    seg = 7'b001_0000;
      glyph_w: seg = 7'b100_0001; // u shape stands in for W
      glyph_i: seg = 7'b100_1111;
      glyph_n: seg = 7'b010_1011;
      glyph_l: seg = 7'b100_0111;
      glyph_e: seg = 7'b000_0110;
      default: seg = 7'b111_1111;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/whack_top.sv */
`timescale 1ns/10ps
`default_nettype none

module whack_top #(
  parameter int tick_div = game_pkg::tick_div_default
) (
  input wire clk,
  input wire out_rst,
  input wire start,
  input wire key_req,
  input wire [8:0] key_code,
  output logic key_ack,
  output logic [15:0] led,
  output logic [3:0] digit,
  output logic [6:0] seg
);

  import game_pkg::*;

  logic game_tick;
  logic scan_en;
  logic key_event;
  logic [3:0] key_digit;
  logic key_is_digit;
  logic key_is_space;
  game_state_e state;
  logic [8:0] lfsr_q;
  disp_word_u disp_word;

  tick_gen #(.tick_div(tick_div)) u_tick (
    .clk(clk), .out_rst(out_rst), .game_tick(game_tick), .scan_en(scan_en)
  );

  key_receiver u_key (
    .clk(clk), .out_rst(out_rst), .key_req(key_req), .key_code(key_code),
    .key_ack(key_ack), .key_event(key_event), .key_digit(key_digit),
    .key_is_digit(key_is_digit), .key_is_space(key_is_space)
  );

  target_lfsr u_lfsr (
    .clk(clk), .out_rst(out_rst), .game_tick(game_tick), .state(state), .lfsr_q(lfsr_q)
  );

  game_ctrl u_ctrl (
    .clk(clk), .out_rst(out_rst), .start(start), .game_tick(game_tick),
    .key_event(key_event), .key_digit(key_digit), .key_is_digit(key_is_digit),
    .key_is_space(key_is_space), .lfsr_q(lfsr_q), .state(state), .led(led),
    .disp_word(disp_word)
  );

  seg_display u_seg (
    .clk(clk), .out_rst(out_rst), .scan_en(scan_en), .disp_word(disp_word),
    .digit(digit), .seg(seg)
  );

endmodule

`default_nettype wire

/* testbench/tb_whack.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_whack;

  import game_pkg::*;

  logic clk;
  logic out_rst;
  logic start;
  logic key_req;
  logic [8:0] key_code;
  wire key_ack;
  wire [15:0] led;
  wire [3:0] digit;
  wire [6:0] seg;

  // game model
  logic [7:0] m_time;
  logic [7:0] m_goal;
  logic m_edit_goal;
  logic [8:0] m_lfsr;
  logic [15:0] m_led;
  int m_score;
  int m_goal_bin;
  logic [15:0] word;
  logic [8:0] code;

  whack_top #(.tick_div(64)) u_dut (
    .clk(clk), .out_rst(out_rst), .start(start), .key_req(key_req), .key_code(key_code),
    .key_ack(key_ack), .led(led), .digit(digit), .seg(seg)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #2_000_000;
    abort("simulation ran past its time limit");
  end

  task automatic abort(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic start_pulse();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  task automatic wait_led_change(input int limit);
    logic [15:0] prev;
    int n;
    prev = led;
    n = 0;
    while (led === prev) begin
      next_cycle();
      n++;
      if (n > limit) abort("led did not change in time");
    end
  endtask

  // first half of the four-phase req/ack, returns just after key_ack rose
  task automatic press_key(input logic [8:0] c);
    int n;
    key_code = c;
    key_req = 1'b1;
    n = 0;
    while (key_ack !== 1'b1) begin
      next_cycle();
      n++;
      if (n > 20) abort("key_ack did not rise");
    end
    key_req = 1'b0;
  endtask

  task automatic release_key();
    int n;
    n = 0;
    while (key_ack !== 1'b0) begin
      next_cycle();
      n++;
      if (n > 20) abort("key_ack did not fall");
    end
  endtask

  task automatic send_key(input logic [8:0] c);
    press_key(c);
    release_key();
  endtask

  function automatic logic is_known(input logic [8:0] c);
    for (int i = 0; i < 20; i++) begin
      if (c == key_code_table[i]) return 1'b1;
    end
    return c == space_code;
  endfunction

  // gfedcba active low, bit 4 flags an unknown shape
  function automatic logic [4:0] seg_to_nib(input logic [6:0] s);
    case (s)
      7'b100_0000: return 5'd0;
      7'b111_1001: return 5'd1;
      7'b010_0100: return 5'd2;
      7'b011_0000: return 5'd3;
      7'b001_1001: return 5'd4;
      7'b001_0010: return 5'd5;
      7'b000_0010: return 5'd6;
      7'b111_1000: return 5'd7;
      7'b000_0000: return 5'd8;
      7'b001_0000: return 5'd9;
      7'b100_0001: return 5'd10; // W
      7'b100_1111: return 5'd11; // I
      7'b010_1011: return 5'd12; // N
      7'b100_0111: return 5'd13; // L
      7'b000_0110: return 5'd14; // E
      7'b111_1111: return 5'd15;
      default:     return 5'h10;
    endcase
  endfunction

  task automatic read_display(output logic [15:0] w);
    logic [3:0] sel;
    logic [4:0] nib;
    int n;
    for (int p = 0; p < 4; p++) begin
      sel = ~(4'b0001 << p);
      n = 0;
      while (digit !== sel) begin
        next_cycle();
        n++;
        if (n > 10) abort("digit select did not come round");
      end
      nib = seg_to_nib(seg);
      if (nib[4]) abort("unknown segment pattern on the display");
      w[p*4 +: 4] = nib[3:0];
    end
  endtask

  // shift toward bit 0, bit 0 wraps to bit 8 and flips bits 6, 5, 3
  function automatic logic [8:0] lfsr_step(input logic [8:0] v);
    logic [8:0] r;
    r = {v[0], v[8:1]};
    if (v[0]) begin
      r[6] = ~r[6];
      r[5] = ~r[5];
      r[3] = ~r[3];
    end
    return r;
  endfunction

  function automatic logic [7:0] to_bcd(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  // idx 0..19 is a digit code, 20 is space
  task automatic setup_key(input int idx);
    if (idx == 20) begin
      send_key(space_code);
      m_edit_goal = !m_edit_goal;
    end else begin
      send_key(key_code_table[idx]);
      if (m_edit_goal) m_goal = {m_goal[3:0], 4'(idx % 10)};
      else m_time = {m_time[3:0], 4'(idx % 10)};
    end
    check("setup led", m_edit_goal ? 16'b0000_0000_1111_1111 : 16'b1111_1111_0000_0000, led);
    read_display(word);
    check("setup display", {m_time, m_goal}, word);
  endtask

  task automatic enter_setup();
    start_pulse();
    m_time = 8'h30;
    m_goal = 8'h10;
    m_edit_goal = 1'b0;
    check("setup entry led", 16'b1111_1111_0000_0000, led);
    read_display(word);
    check("setup entry display", {m_time, m_goal}, word);
  endtask

  task automatic enter_settings(input logic [7:0] t, input logic [7:0] g);
    if (m_edit_goal) setup_key(20);
    setup_key(int'(t[7:4]));
    setup_key(int'(t[3:0]));
    setup_key(20);
    setup_key(int'(g[7:4]));
    setup_key(int'(g[3:0]));
  endtask

  task automatic begin_play(input string name);
    int t;
    start_pulse();
    m_lfsr = lfsr_seed;
    m_led = {m_lfsr, 7'b000_0011};
    m_score = 0;
    m_goal_bin = m_goal[7:4] * 10 + m_goal[3:0];
    t = m_time[7:4] * 10 + m_time[3:0];
    check({name, " led"}, m_led, led);
    read_display(word);
    check({name, " score"}, 16'h0000, {8'h00, word[7:0]});
    if (t > 0 && word[15:8] == to_bcd(t - 1)) t = t - 1; // tick during the read
    check({name, " time"}, {8'h00, to_bcd(t)}, {8'h00, word[15:8]});
  endtask

  task automatic hit_key(input int idx);
    int k;
    k = idx % 10;
    press_key(key_code_table[idx]);
    next_cycle(); // two clocks after req was sampled
    if (m_led[15-k]) begin
      m_led[15-k] = 1'b0;
      m_score++;
    end
    check("hit led", m_led, led);
    release_key();
    if (m_score < m_goal_bin) begin
      read_display(word);
      check("hit score", {8'h00, to_bcd(m_score)}, {8'h00, word[7:0]});
    end
  endtask

  // four inversions, the glyphs, then back to idle
  task automatic check_flash(input string name, input logic [15:0] glyphs);
    logic [15:0] prev;
    prev = led;
    for (int i = 0; i < 4; i++) begin
      wait_led_change(400);
      check({name, " led"}, ~prev, led);
      prev = led;
      if (i == 0) begin
        read_display(word);
        check({name, " glyphs"}, glyphs, word);
      end
    end
    wait_led_change(400);
    check({name, " idle led"}, 16'b1000_0000_0000_0000, led);
  endtask

  initial begin
    out_rst = 1'b1;
    start = 1'b0;
    key_req = 1'b0;
    key_code = 9'd0;
    void'($urandom(32'h87f6));
    repeat (3) @(posedge clk);
    #1;
    out_rst = 1'b0;

    check("reset led", 16'b1000_0000_0000_0000, led);
    check("reset ack", 16'h0000, {15'd0, key_ack});
    check("reset digit", 16'h000f, {12'd0, digit});
    read_display(word);
    check("idle display", 16'hffff, word);
    for (int i = 0; i < 10; i++) begin
      code = 9'($urandom);
      while (is_known(code)) code = 9'($urandom);
      if (i % 3 == 0) code = key_code_table[$urandom % 20];
      send_key(code);
      check("idle led after key", 16'b1000_0000_0000_0000, led);
    end

    enter_setup();
    for (int i = 0; i < 12; i++) begin
      if ($urandom % 4 == 0) setup_key(20);
      else setup_key(int'($urandom % 20));
    end
    enter_settings(8'h40, 8'h08);

    begin_play("win entry");
    for (int i = 0; i < 12; i++) hit_key(int'($urandom % 20));
    while (m_score < m_goal_bin) begin
      repeat (target_ticks) m_lfsr = lfsr_step(m_lfsr);
      m_led = {m_lfsr, 7'b000_0011};
      wait_led_change(600);
      check("refresh led", m_led, led);
      for (int b = 15; b >= 7 && m_score < m_goal_bin; b--) begin
        if (m_led[b]) hit_key(15 - b);
      end
    end
    check_flash("win", 16'habcf);

    enter_setup();
    enter_settings(8'h03, 8'h99);
    begin_play("loss entry");
    check_flash("loss", 16'hd05e);
    read_display(word);
    check("idle display after loss", 16'hffff, word);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/game_pkg.sv
verilog/tick_gen.sv
verilog/key_receiver.sv
verilog/target_lfsr.sv
verilog/game_ctrl.sv
verilog/seg_display.sv
verilog/whack_top.sv
testbench/tb_whack.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_whack -f src.f -o sim_whack
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_whack 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
